/* logic/csi_pkg.sv */
package csi_pkg;

    localparam int NUM_LANES      = 4;
    localparam int LANE_WORD_BITS = NUM_LANES * 8;       // One byte per lane per cycle

    // Data types at or above this value carry a payload
    localparam logic [5:0] LONG_PACKET_MIN_DT = 6'h10;

    // Lane 0 byte in data[7:0]
    typedef struct packed {
        logic                      valid;
        logic [LANE_WORD_BITS-1:0] data;
    } csi_word_t;

    typedef enum logic [5:0] {
        FRAME_START = 6'h00,
        FRAME_END   = 6'h01,
        LINE_START  = 6'h02,
        LINE_END    = 6'h03,
        RAW10       = 6'h2B
    } csi_dt_e;

    // Byte 0 in the low bits, so the members run from byte 3 down
    typedef struct packed {
        logic [7:0]  ecc;                                // Byte 3
        logic [15:0] word_count;                         // Bytes 2 and 1, byte 1 low
        logic [1:0]  vc;                                 // Byte 0 upper bits
        csi_dt_e     dt;                                 // Byte 0 lower bits
    } csi_header_t;

    typedef struct packed {
        logic                      valid;
        logic                      last;                 // Final word of the packet
        logic [LANE_WORD_BITS-1:0] data;
    } payload_beat_t;

endpackage

/* logic/video_pkg.sv */
package video_pkg;

    localparam int PIXEL_BITS        = 10;
    localparam int PIXELS_PER_GROUP  = 4;
    localparam int RAW10_GROUP_BYTES = 5;                // Four MSB bytes plus one LSB byte
    localparam int MAX_LINE_GROUPS   = 64;               // 256 pixels per camera line
    localparam int GROUP_ADDR_BITS   = $clog2(MAX_LINE_GROUPS);

    // Pixel 0 in the low 10 bits
    typedef logic [PIXELS_PER_GROUP-1:0][PIXEL_BITS-1:0] pixel_group_t;

    typedef struct packed {
        logic         valid;
        logic         last;                              // Final group of a line
        pixel_group_t pixels;
    } video_beat_t;

endpackage

/* logic/csi_packet_decoder.sv */
`timescale 1ns/1ns

module csi_packet_decoder import csi_pkg::*; (
    input  logic          clk_byte_hs,
    input  logic          reset_n_i,
    input  csi_word_t     lane_i,
    output payload_beat_t payload_o,
    output logic          frame_valid_o
);

    typedef enum logic [1:0] {
        HEADER,
        RAW10_PAYLOAD,
        SKIP_PAYLOAD
    } dec_state_e;

    dec_state_e                state_q;
    csi_header_t               hdr;
    logic                      is_long;
    logic                      take_word;
    logic [13:0]               words_left_q;         // Payload words still expected
    logic                      beat_valid_q;
    logic                      beat_last_q;
    logic [LANE_WORD_BITS-1:0] beat_data_q;
    logic                      frame_valid_q;

    assign hdr = csi_header_t'(lane_i.data);

    // Zero-length long packets have no payload to track
    assign is_long = (hdr.dt >= LONG_PACKET_MIN_DT) && (hdr.word_count[15:2] != '0);

    assign take_word = lane_i.valid && (state_q == RAW10_PAYLOAD) && (words_left_q != '0);

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state_q      <= HEADER;
            words_left_q <= '0;
        end
        else
        begin
            case (state_q)
                HEADER:
                begin
                    if (lane_i.valid && is_long)
                    begin
                        words_left_q <= hdr.word_count[15:2];    // Bytes to 32-bit words
                        state_q      <= (hdr.dt == RAW10) ? RAW10_PAYLOAD : SKIP_PAYLOAD;
                    end
                end
                RAW10_PAYLOAD, SKIP_PAYLOAD:
                begin
                    if (!lane_i.valid)
                    begin
                        state_q <= HEADER;                       // Packet run has ended
                    end
                    else if (words_left_q != '0)
                    begin
                        words_left_q <= words_left_q - 1'b1;
                    end
                end
                default:
                begin
                    state_q <= HEADER;
                end
            endcase
        end
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            frame_valid_q <= 1'b0;
        end
        else if (lane_i.valid && (state_q == HEADER))
        begin
            case (hdr.dt)
                FRAME_START: frame_valid_q <= 1'b1;
                FRAME_END:   frame_valid_q <= 1'b0;
                default:     frame_valid_q <= frame_valid_q;   // Line markers are ignored
            endcase
        end
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            beat_valid_q <= 1'b0;
            beat_last_q  <= 1'b0;
        end
        else
        begin
            beat_valid_q <= take_word;
            beat_last_q  <= take_word && (words_left_q == 14'd1);
        end
    end

    always_ff @(posedge clk_byte_hs)
    begin
        if (take_word)
        begin
            beat_data_q <= lane_i.data;
        end
    end

    assign payload_o = '{valid: beat_valid_q, last: beat_last_q, data: beat_data_q};

    assign frame_valid_o = frame_valid_q;

endmodule

/* logic/raw10_unpacker.sv */
`timescale 1ns/1ns

module raw10_unpacker import csi_pkg::*, video_pkg::*; (
    input  logic          clk_byte_hs,
    input  logic          reset_n_i,
    input  payload_beat_t payload_i,
    output video_beat_t   group_o
);

    // Byte 0 is the oldest byte in the accumulator
    logic [2*NUM_LANES-1:0][7:0] acc_q;
    logic [2*NUM_LANES-1:0][7:0] merged;
    logic [3:0]                  count_q;            // Bytes held, at most 4 between words
    logic [3:0]                  merged_count;
    logic                        emit;
    pixel_group_t                unpacked;
    logic                        grp_valid_q;
    logic                        grp_last_q;
    pixel_group_t                grp_pixels_q;

    always_comb
    begin
        merged       = acc_q;
        merged_count = count_q;
        if (payload_i.valid)
        begin
            for (int i = 0; i < NUM_LANES; i++)
            begin
                merged[count_q + i] = payload_i.data[8*i +: 8];    // Append after held bytes
            end
            merged_count = count_q + 4'(NUM_LANES);
        end
    end

    assign emit = merged_count >= 4'(RAW10_GROUP_BYTES);

    // MSBs from bytes 0 to 3, two LSBs per pixel from byte 4
    always_comb
    begin
        for (int k = 0; k < PIXELS_PER_GROUP; k++)
        begin
            unpacked[k] = {merged[k],
                           merged[RAW10_GROUP_BYTES-1][(PIXEL_BITS-8)*k +: (PIXEL_BITS-8)]};
        end
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            count_q     <= '0;
            grp_valid_q <= 1'b0;
            grp_last_q  <= 1'b0;
        end
        else
        begin
            if (payload_i.valid && payload_i.last)
            begin
                count_q <= '0;                       // Payload ends on a group boundary
            end
            else if (emit)
            begin
                count_q <= merged_count - 4'(RAW10_GROUP_BYTES);
            end
            else
            begin
                count_q <= merged_count;
            end
            grp_valid_q <= emit;
            grp_last_q  <= emit && payload_i.valid && payload_i.last;
        end
    end

    always_ff @(posedge clk_byte_hs)
    begin
        if (emit)
        begin
            acc_q        <= merged >> (RAW10_GROUP_BYTES * 8);    // Drop the consumed group
            grp_pixels_q <= unpacked;
        end
        else
        begin
            acc_q <= merged;
        end
    end

    assign group_o = '{valid: grp_valid_q, last: grp_last_q, pixels: grp_pixels_q};

endmodule

/* logic/pixel_group_fifo.sv */
`timescale 1ns/1ns

module pixel_group_fifo import video_pkg::*; (
    input  logic        clk_byte_hs,
    input  logic        reset_n_i,
    input  video_beat_t push_i,
    input  logic        pop_i,
    output video_beat_t head_o,
    output logic        line_ready_o
);

    pixel_group_t             mem_pixels [MAX_LINE_GROUPS];
    logic                     mem_last   [MAX_LINE_GROUPS];
    logic [GROUP_ADDR_BITS:0] wr_ptr_q;                  // Extra bit tells full from empty
    logic [GROUP_ADDR_BITS:0] rd_ptr_q;
    logic [GROUP_ADDR_BITS:0] line_cnt_q;                // Complete lines held
    logic                     empty;
    logic                     do_pop;
    logic                     push_line;
    logic                     pop_line;

    assign empty     = wr_ptr_q == rd_ptr_q;
    assign do_pop    = pop_i && !empty;
    assign push_line = push_i.valid && push_i.last;
    assign pop_line  = do_pop && mem_last[rd_ptr_q[GROUP_ADDR_BITS-1:0]];

    always_ff @(posedge clk_byte_hs)
    begin
        if (push_i.valid)
        begin
            mem_pixels[wr_ptr_q[GROUP_ADDR_BITS-1:0]] <= push_i.pixels;
            mem_last[wr_ptr_q[GROUP_ADDR_BITS-1:0]]   <= push_i.last;
        end
    end

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            line_cnt_q <= '0;
        end
        else
        begin
            if (push_i.valid)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_line, pop_line})
                2'b10:   line_cnt_q <= line_cnt_q + 1'b1;
                2'b01:   line_cnt_q <= line_cnt_q - 1'b1;
                default: line_cnt_q <= line_cnt_q;      // Both or neither leave it unchanged
            endcase
        end
    end

    assign head_o = '{valid:  !empty,
                      last:   mem_last[rd_ptr_q[GROUP_ADDR_BITS-1:0]],
                      pixels: mem_pixels[rd_ptr_q[GROUP_ADDR_BITS-1:0]]};

    assign line_ready_o = line_cnt_q != '0;

endmodule

/* logic/side_by_side_merger.sv */
`timescale 1ns/1ns

module side_by_side_merger import video_pkg::*; (
    input  logic        clk_byte_hs,
    input  logic        reset_n_i,
    input  video_beat_t group_a_i,
    input  video_beat_t group_b_i,
    input  logic        frame_valid_a_i,
    input  logic        frame_valid_b_i,
    output video_beat_t video_o,
    output logic        frame_valid_o
);

    typedef enum logic [1:0] {
        WAIT_LINES,
        SEND_A,
        SEND_B
    } merge_state_e;

    merge_state_e state_q;
    video_beat_t  head_a;
    video_beat_t  head_b;
    logic         ready_a;
    logic         ready_b;
    logic         pop_a;
    logic         pop_b;
    logic         out_valid_q;
    logic         out_last_q;
    pixel_group_t out_pixels_q;
    logic         frame_valid_q;

    pixel_group_fifo u_fifo_a (
        .clk_byte_hs  (clk_byte_hs),
        .reset_n_i    (reset_n_i),
        .push_i       (group_a_i),
        .pop_i        (pop_a),
        .head_o       (head_a),
        .line_ready_o (ready_a)
    );

    pixel_group_fifo u_fifo_b (
        .clk_byte_hs  (clk_byte_hs),
        .reset_n_i    (reset_n_i),
        .push_i       (group_b_i),
        .pop_i        (pop_b),
        .head_o       (head_b),
        .line_ready_o (ready_b)
    );

    assign pop_a = (state_q == SEND_A) && head_a.valid;
    assign pop_b = (state_q == SEND_B) && head_b.valid;

    always_ff @(posedge clk_byte_hs or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state_q       <= WAIT_LINES;
            out_valid_q   <= 1'b0;
            out_last_q    <= 1'b0;
            frame_valid_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                WAIT_LINES: if (ready_a && ready_b) state_q <= SEND_A;
                SEND_A:     if (pop_a && head_a.last) state_q <= SEND_B;
                SEND_B:     if (pop_b && head_b.last) state_q <= WAIT_LINES;
                default:    state_q <= WAIT_LINES;
            endcase
            out_valid_q   <= pop_a || pop_b;
            out_last_q    <= pop_b && head_b.last;        // A's last is not forwarded
            frame_valid_q <= frame_valid_a_i || frame_valid_b_i;
        end
    end

    always_ff @(posedge clk_byte_hs)
    begin
        if (pop_a)
        begin
            out_pixels_q <= head_a.pixels;
        end
        else if (pop_b)
        begin
            out_pixels_q <= head_b.pixels;
        end
    end

    assign video_o = '{valid: out_valid_q, last: out_last_q, pixels: out_pixels_q};

    assign frame_valid_o = frame_valid_q;

endmodule

/* logic/dual_camera_merge_top.sv */
`timescale 1ns/1ns

module dual_camera_merge_top import csi_pkg::*, video_pkg::*; (
    input  logic        clk_byte_hs,
    input  logic        reset_n_i,
    input  csi_word_t   cam_a_i,
    input  csi_word_t   cam_b_i,
    output video_beat_t video_o,
    output logic        frame_valid_o
);

    payload_beat_t payload_a;
    payload_beat_t payload_b;
    video_beat_t   group_a;
    video_beat_t   group_b;
    logic          frame_valid_a;
    logic          frame_valid_b;

    csi_packet_decoder u_decoder_a (
        .clk_byte_hs   (clk_byte_hs),
        .reset_n_i     (reset_n_i),
        .lane_i        (cam_a_i),
        .payload_o     (payload_a),
        .frame_valid_o (frame_valid_a)
    );

    csi_packet_decoder u_decoder_b (
        .clk_byte_hs   (clk_byte_hs),
        .reset_n_i     (reset_n_i),
        .lane_i        (cam_b_i),
        .payload_o     (payload_b),
        .frame_valid_o (frame_valid_b)
    );

    raw10_unpacker u_unpacker_a (
        .clk_byte_hs (clk_byte_hs),
        .reset_n_i   (reset_n_i),
        .payload_i   (payload_a),
        .group_o     (group_a)
    );

    raw10_unpacker u_unpacker_b (
        .clk_byte_hs (clk_byte_hs),
        .reset_n_i   (reset_n_i),
        .payload_i   (payload_b),
        .group_o     (group_b)
    );

    side_by_side_merger u_merger (
        .clk_byte_hs     (clk_byte_hs),
        .reset_n_i       (reset_n_i),
        .group_a_i       (group_a),
        .group_b_i       (group_b),
        .frame_valid_a_i (frame_valid_a),
        .frame_valid_b_i (frame_valid_b),
        .video_o         (video_o),
        .frame_valid_o   (frame_valid_o)
    );

endmodule

/* dv/tb_line_table.svh */
`ifndef TB_LINE_TABLE_SVH
`define TB_LINE_TABLE_SVH

// One merged line per entry, a pixel count of 0 sends no packet on that camera
typedef struct packed {
    logic [8:0] a_pixels;
    logic [8:0] b_pixels;
    logic [5:0] b_dt;
    logic       frame_start;                    // Frame Start on both cameras before the line
    logic       frame_end;                      // Frame End on both cameras after the line
} line_entry_t;

localparam int NUM_LINES = 6;

localparam line_entry_t LINE_TABLE [NUM_LINES] = '{
    '{9'd64,  9'd64,  RAW10, 1'b1, 1'b0},
    '{9'd16,  9'd64,  RAW10, 1'b0, 1'b0},       // Unequal lengths
    '{9'd0,   9'd32,  6'h12, 1'b0, 1'b0},       // Non-RAW10 long packet on B only
    '{9'd48,  9'd16,  RAW10, 1'b0, 1'b0},
    '{9'd256, 9'd256, RAW10, 1'b0, 1'b0},       // Longest supported line
    '{9'd32,  9'd32,  RAW10, 1'b0, 1'b1}
};

function automatic logic [31:0] packet_header(input logic [5:0] dt, input logic [15:0] wc);
    return {8'h00, wc, 2'b00, dt};              // VC 0, ECC unused
endfunction

// Five bytes per group, byte 0 in the low bits
function automatic logic [39:0] raw10_bytes(input pixel_group_t grp);
    logic [39:0] bytes;
    for (int k = 0; k < 4; k++)
    begin
        bytes[8*k +: 8]      = grp[k][9:2];     // Upper 8 bits
        bytes[32 + 2*k +: 2] = grp[k][1:0];     // Low 2 bits share byte 4
    end
    return bytes;
endfunction

function automatic int packet_words(input int pixels);
    return (pixels == 0) ? 0 : 1 + pixels * 5 / 16;    // Header plus payload words
endfunction

function automatic int table_word_count();
    int total;
    total = 0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
        total += packet_words(LINE_TABLE[i].a_pixels) + packet_words(LINE_TABLE[i].b_pixels);
        total += 2 * (LINE_TABLE[i].frame_start + LINE_TABLE[i].frame_end);
    end
    return total;
endfunction

`endif

/* dv/tb_dual_camera_merge.sv */
`timescale 1ns/1ns

module tb_dual_camera_merge import csi_pkg::*, video_pkg::*; ();

    `include "tb_line_table.svh"

    localparam int DRAIN_CYCLES = 16;           // Quiet window after each line

    logic         clk_byte_hs;
    logic         reset_n_i;
    csi_word_t    cam_a_i;
    csi_word_t    cam_b_i;
    video_beat_t  video_o;
    logic         frame_valid_o;

    logic [31:0]  tx_a [$];
    logic [31:0]  tx_b [$];
    pixel_group_t grp_a [$];
    pixel_group_t grp_b [$];
    pixel_group_t exp_pix [$];                  // Expected merged line
    logic         exp_last [$];
    logic [31:0]  lcg_state = 32'd16736;
    int           errors = 0;
    int           tests = 0;
    int           failed_tests = 0;
    int           cycle_count = 0;

    dual_camera_merge_top u_dut (
        .clk_byte_hs   (clk_byte_hs),
        .reset_n_i     (reset_n_i),
        .cam_a_i       (cam_a_i),
        .cam_b_i       (cam_b_i),
        .video_o       (video_o),
        .frame_valid_o (frame_valid_o)
    );

    always #5 clk_byte_hs = ~clk_byte_hs;

    function automatic logic [9:0] next_pixel();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[25:16];
    endfunction

    task automatic report_mismatch(input string sig, input logic [39:0] expected,
                                   input logic [39:0] actual);
        errors++;
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                 $time, sig, expected, actual);
    endtask

    task automatic build_line(input logic to_b, input int pixels, input logic [5:0] dt);
        logic [7:0]   bytes [$];
        logic [31:0]  word_q [$];
        pixel_group_t grp;
        logic [39:0]  group_bytes;
        for (int g = 0; g < pixels / 4; g++)
        begin
            for (int k = 0; k < 4; k++)
                grp[k] = next_pixel();
            if (to_b)
                grp_b.push_back(grp);
            else
                grp_a.push_back(grp);
            group_bytes = raw10_bytes(grp);
            for (int n = 0; n < 5; n++)
                bytes.push_back(group_bytes[8*n +: 8]);
        end
        word_q.push_back(packet_header(dt, 16'(pixels * 5 / 4)));
        for (int w = 0; w < bytes.size(); w += 4)
            word_q.push_back({bytes[w+3], bytes[w+2], bytes[w+1], bytes[w]});   // Lane 0 low
        if (to_b)
            tx_b = word_q;
        else
            tx_a = word_q;
    endtask

    // Both cameras in parallel and each drops valid when its packet ends
    task automatic drive_packets();
        int n;
        n = (tx_a.size() > tx_b.size()) ? tx_a.size() : tx_b.size();
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk_byte_hs);
            #1;
            cam_a_i = '{valid: i < tx_a.size(), data: (i < tx_a.size()) ? tx_a[i] : 32'h0};
            cam_b_i = '{valid: i < tx_b.size(), data: (i < tx_b.size()) ? tx_b[i] : 32'h0};
        end
        @(posedge clk_byte_hs);
        #1;
        cam_a_i = '0;
        cam_b_i = '0;
        tx_a    = {};
        tx_b    = {};
    endtask

    task automatic send_frame_marker(input logic [5:0] dt, input logic to_a, input logic to_b,
                                     input logic expected);
        if (to_a)
            tx_a.push_back(packet_header(dt, 16'd1));
        if (to_b)
            tx_b.push_back(packet_header(dt, 16'd1));
        drive_packets();
        repeat (3) @(negedge clk_byte_hs);      // Decoder flag, then merger register
        assert (frame_valid_o == expected)
        else report_mismatch("frame_valid_o", expected, frame_valid_o);
    endtask

    task automatic queue_merged_line();
        foreach (grp_a[i])
        begin
            exp_pix.push_back(grp_a[i]);
            exp_last.push_back(1'b0);
        end
        foreach (grp_b[i])
        begin
            exp_pix.push_back(grp_b[i]);
            exp_last.push_back(i == grp_b.size() - 1);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    always @(negedge clk_byte_hs)
    begin
        if (reset_n_i && video_o.valid)
        begin
            assert (exp_pix.size() != 0)
            else
            begin
                errors++;
                $display("Output beat at %0t arrived with no merged line pending", $time);
            end
            if (exp_pix.size() != 0)
            begin
                assert (video_o.pixels == exp_pix[0])
                else report_mismatch("video_o.pixels", exp_pix[0], video_o.pixels);
                assert (video_o.last == exp_last[0])
                else report_mismatch("video_o.last", exp_last[0], video_o.last);
                assert (frame_valid_o)
                else report_mismatch("frame_valid_o", 1'b1, frame_valid_o);
                exp_pix.delete(0);
                exp_last.delete(0);
            end
        end
    end

    initial
    begin
        int limit;
        limit = table_word_count() * 4 + 1000;
        while (cycle_count < limit)
        begin
            @(posedge clk_byte_hs);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with lines still unchecked", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        line_entry_t entry;
        int          errors_before;
        clk_byte_hs = 1'b0;
        reset_n_i   = 1'b0;
        cam_a_i     = '0;
        cam_b_i     = '0;
        repeat (8) @(posedge clk_byte_hs);
        #1;
        reset_n_i = 1'b1;

        errors_before = errors;
        repeat (4)
        begin
            @(negedge clk_byte_hs);
            assert (!video_o.valid) else report_mismatch("video_o.valid", 1'b0, video_o.valid);
            assert (!frame_valid_o) else report_mismatch("frame_valid_o", 1'b0, frame_valid_o);
        end
        finish_test("idle after reset", errors_before);

        for (int t = 0; t < NUM_LINES; t++)
        begin
            entry         = LINE_TABLE[t];
            errors_before = errors;
            if (entry.frame_start)
            begin
                send_frame_marker(FRAME_START, 1'b1, 1'b0, 1'b1);   // Camera A alone opens it
                send_frame_marker(FRAME_START, 1'b0, 1'b1, 1'b1);
            end
            grp_a = {};
            grp_b = {};
            if (entry.a_pixels != 0)
                build_line(1'b0, entry.a_pixels, RAW10);
            if (entry.b_pixels != 0)
                build_line(1'b1, entry.b_pixels, entry.b_dt);
            if (entry.b_dt == RAW10 && entry.a_pixels != 0 && entry.b_pixels != 0)
                queue_merged_line();
            drive_packets();
            while (exp_pix.size() != 0)
                @(negedge clk_byte_hs);
            repeat (DRAIN_CYCLES) @(negedge clk_byte_hs);
            if (entry.frame_end)
            begin
                send_frame_marker(FRAME_END, 1'b1, 1'b0, 1'b1);     // Camera B still in frame
                send_frame_marker(FRAME_END, 1'b0, 1'b1, 1'b0);
            end
            finish_test($sformatf("line A=%0d B=%0d dt=%02h", entry.a_pixels,
                                  entry.b_pixels, entry.b_dt), errors_before);
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
logic/csi_pkg.sv
logic/video_pkg.sv
logic/csi_packet_decoder.sv
logic/raw10_unpacker.sv
logic/pixel_group_fifo.sv
logic/side_by_side_merger.sv
logic/dual_camera_merge_top.sv
dv/tb_dual_camera_merge.sv

/* Bender.yml */
package:
  name: dual_camera_merge

sources:
  - logic/csi_pkg.sv
  - logic/video_pkg.sv
  - logic/csi_packet_decoder.sv
  - logic/raw10_unpacker.sv
  - logic/pixel_group_fifo.sv
  - logic/side_by_side_merger.sv
  - logic/dual_camera_merge_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_dual_camera_merge.sv
